//--- Makefile
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= dcache.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- dcache.f
rtl/dcache_pkg.sv
rtl/bus_pkg.sv
rtl/dcache_data_ram.sv
rtl/dcache_tag_array.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
sim/dcache_mem_model.sv
sim/dcache_assert.sv
sim/dcache_tb.sv

//--- rtl/bus_pkg.sv
// 64-bit data bus shared by core and memory sides; bursts carry no length or last field
`default_nettype none

package bus_pkg;

  localparam int unsigned WORD_W = 64;
  localparam int unsigned STRB_W = WORD_W / 8;

  typedef logic [WORD_W-1:0] bus_word_t;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } bus_resp_e;

  // one write beat, strobe bit per byte
  typedef struct packed {
    bus_word_t         data;
    logic [STRB_W-1:0] strb;
  } wbeat_t;

endpackage

`default_nettype wire

//--- rtl/dcache_ctrl.sv
// one request at a time, read wins over write; memory responses ignored, core always gets OKAY
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl
  import dcache_pkg::*;
  import bus_pkg::*;
(
  input  wire               clk,
  input  wire               rst,
  // core side
  input  wire               core_ar_valid_i,
  output logic              core_ar_ready_o,
  input  wire dcache_addr_t core_ar_addr_i,
  output logic              core_r_valid_o,
  input  wire               core_r_ready_i,
  output bus_word_t         core_r_data_o,
  input  wire               core_aw_valid_i,
  output logic              core_aw_ready_o,
  input  wire dcache_addr_t core_aw_addr_i,
  input  wire               core_w_valid_i,
  output logic              core_w_ready_o,
  input  wire wbeat_t       core_w_i,
  output logic              core_b_valid_o,
  input  wire               core_b_ready_i,
  output bus_resp_e         core_b_resp_o,
  // memory side
  output logic              mem_ar_valid_o,
  input  wire               mem_ar_ready_i,
  output dcache_addr_t      mem_ar_addr_o,
  input  wire               mem_r_valid_i,
  output logic              mem_r_ready_o,
  input  wire bus_word_t    mem_r_data_i,
  input  wire bus_resp_e    mem_r_resp_i,
  output logic              mem_aw_valid_o,
  input  wire               mem_aw_ready_i,
  output dcache_addr_t      mem_aw_addr_o,
  output logic              mem_w_valid_o,
  input  wire               mem_w_ready_i,
  output wbeat_t            mem_w_o,
  input  wire               mem_b_valid_i,
  output logic              mem_b_ready_o,
  input  wire bus_resp_e    mem_b_resp_i,
  // tag array
  output dcache_addr_t      lookup_o,
  input  wire               hit_i,
  input  wire way_t         hit_way_i,
  input  wire way_t         victim_way_i,
  input  wire               victim_dirty_i,
  input  wire tag_t         victim_tag_i,
  output logic              upd_en_o,
  output tag_upd_t          upd_o,
  // data ways
  output logic [1:0]        way_we_o,
  output index_t            ram_index_o,
  output line_be_t          ram_be_o,
  output line_t             ram_wdata_o,
  input  wire line_t        way0_rdata_i,
  input  wire line_t        way1_rdata_i
);

  dcache_state_e state_q;
  logic          is_write_q;
  logic          refill_q;    // line_q holds the fresh line, ram output still stale
  logic          beat_q;      // burst beat, low word first
  logic          r_valid_q;
  logic          b_valid_q;
  dcache_addr_t  addr_q;
  way_t          way_q;
  tag_t          victim_tag_q;
  line_t         line_q;
  bus_word_t     r_data_q;

  logic          accept;
  logic          core_r_fire;
  logic          core_w_fire;
  logic          core_b_fire;
  logic          mem_ar_fire;
  logic          mem_r_fire;
  logic          mem_aw_fire;
  logic          mem_w_fire;
  logic          mem_b_fire;
  logic          ram_we;
  line_t         way_line;
  line_t         src_line;

  assign core_ar_ready_o = (state_q == S_IDLE);
  assign core_aw_ready_o = (state_q == S_IDLE) && !core_ar_valid_i;  // read wins
  assign core_r_valid_o  = r_valid_q;
  assign core_r_data_o   = r_data_q;
  assign core_w_ready_o  = (state_q == S_HIT) && is_write_q && !b_valid_q;
  assign core_b_valid_o  = b_valid_q;
  assign core_b_resp_o   = OKAY;

  assign mem_ar_valid_o = (state_q == S_AR);
  assign mem_ar_addr_o  = '{tag: addr_q.tag, index: addr_q.index, offset: '0};
  assign mem_r_ready_o  = (state_q == S_R);
  assign mem_aw_valid_o = (state_q == S_AW);
  assign mem_aw_addr_o  = '{tag: victim_tag_q, index: addr_q.index, offset: '0};
  assign mem_w_valid_o  = (state_q == S_W);
  assign mem_w_o        = '{data: beat_q ? line_q[127:64] : line_q[63:0], strb: '1};
  assign mem_b_ready_o  = (state_q == S_B);

  assign accept      = (state_q == S_IDLE) && (core_ar_valid_i || core_aw_valid_i);
  assign core_r_fire = core_r_valid_o && core_r_ready_i;
  assign core_w_fire = core_w_valid_i && core_w_ready_o;
  assign core_b_fire = core_b_valid_o && core_b_ready_i;
  assign mem_ar_fire = mem_ar_valid_o && mem_ar_ready_i;
  assign mem_r_fire  = mem_r_valid_i && mem_r_ready_o;
  assign mem_aw_fire = mem_aw_valid_o && mem_aw_ready_i;
  assign mem_w_fire  = mem_w_valid_o && mem_w_ready_i;
  assign mem_b_fire  = mem_b_valid_i && mem_b_ready_o;

  // incoming address while idle, so the ram reads in the accept cycle
  assign lookup_o    = (state_q != S_IDLE) ? addr_q :
                       core_ar_valid_i ? core_ar_addr_i : core_aw_addr_i;
  assign ram_index_o = lookup_o.index;

  assign way_line = way_q ? way1_rdata_i : way0_rdata_i;
  assign src_line = refill_q ? line_q : way_line;

  // array writes
  always_comb begin
    upd_en_o    = 1'b0;
    upd_o       = '{way: way_q, index: addr_q.index, tag: addr_q.tag, valid: 1'b1, dirty: 1'b0};
    ram_we      = 1'b0;
    ram_be_o    = '1;
    ram_wdata_o = {mem_r_data_i, line_q[63:0]};  // whole refilled line
    case (state_q)
      S_B: begin
        if (mem_b_fire) begin
          upd_en_o    = 1'b1;
          upd_o.tag   = victim_tag_q;
          upd_o.valid = 1'b0;  // clean, refill follows
        end
      end
      S_R: begin
        if (mem_r_fire && beat_q) begin
          upd_en_o = 1'b1;
          ram_we   = 1'b1;
        end
      end
      S_HIT: begin
        if (core_w_fire) begin
          upd_en_o    = 1'b1;
          upd_o.dirty = 1'b1;
          ram_we      = 1'b1;
          ram_be_o    = addr_q.offset[3] ? {core_w_i.strb, 8'h00} : {8'h00, core_w_i.strb};
          ram_wdata_o = {core_w_i.data, core_w_i.data};
        end
      end
      default: ;
    endcase
  end

  assign way_we_o = {ram_we && way_q, ram_we && !way_q};

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= S_IDLE;
      is_write_q <= 1'b0;
      refill_q   <= 1'b0;
      beat_q     <= 1'b0;
      r_valid_q  <= 1'b0;
      b_valid_q  <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (accept) begin
            is_write_q <= !core_ar_valid_i;
            refill_q   <= 1'b0;
            beat_q     <= 1'b0;
            if (hit_i) begin
              state_q <= S_HIT;
            end else if (victim_dirty_i) begin
              state_q <= S_AW;
            end else begin
              state_q <= S_AR;
            end
          end
        end
        S_HIT: begin
          if (is_write_q) begin
            if (core_w_fire) b_valid_q <= 1'b1;
            if (core_b_fire) begin
              b_valid_q <= 1'b0;
              state_q   <= S_IDLE;
            end
          end else if (core_r_fire) begin
            r_valid_q <= 1'b0;
            state_q   <= S_IDLE;
          end else begin
            r_valid_q <= 1'b1;  // word lands in r_data_q this cycle
          end
        end
        S_AW: if (mem_aw_fire) state_q <= S_W;
        S_W: begin
          if (mem_w_fire) begin
            beat_q <= ~beat_q;
            if (beat_q) state_q <= S_B;
          end
        end
        S_B: if (mem_b_fire) state_q <= S_AR;
        S_AR: if (mem_ar_fire) state_q <= S_R;
        S_R: begin
          if (mem_r_fire) begin
            beat_q <= ~beat_q;
            if (beat_q) begin
              refill_q <= 1'b1;
              state_q  <= S_HIT;
            end
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // request payload
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q       <= lookup_o;
      way_q        <= hit_i ? hit_way_i : victim_way_i;
      victim_tag_q <= victim_tag_i;
    end
    if (mem_aw_fire) begin
      line_q <= way_line;  // victim stays on the ram output during S_AW
    end else if (mem_r_fire) begin
      if (beat_q) begin
        line_q[127:64] <= mem_r_data_i;
      end else begin
        line_q[63:0] <= mem_r_data_i;
      end
    end
    if (state_q == S_HIT && !is_write_q && !r_valid_q) begin
      r_data_q <= addr_q.offset[3] ? src_line[127:64] : src_line[63:0];
    end
  end

endmodule

`default_nettype wire

//--- rtl/dcache_data_ram.sv
// behavioral line store standing in for an SRAM macro; read-during-write returns old data
`timescale 1ns/1ps
`default_nettype none

module dcache_data_ram
  import dcache_pkg::*;
(
  input  wire           clk,
  input  wire           we_i,
  input  wire index_t   addr_i,
  input  wire line_be_t be_i,
  input  wire line_t    wdata_i,
  output line_t         rdata_o
);

  line_t mem_q [NUM_SETS];

  always_ff @(posedge clk) begin
    for (int b = 0; b < LINE_BYTES; b++) begin
      if (we_i && be_i[b]) begin
        mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
      end
    end
    rdata_o <= mem_q[addr_i];  // read every cycle
  end

endmodule

`default_nettype wire

//--- rtl/dcache_pkg.sv
// geometry fixed at 2 ways x 64 sets x 16-byte lines, 32-bit physical address only
`default_nettype none

package dcache_pkg;

  localparam int unsigned TAG_W      = 22;
  localparam int unsigned INDEX_W    = 6;
  localparam int unsigned OFFSET_W   = 4;
  localparam int unsigned NUM_SETS   = 1 << INDEX_W;
  localparam int unsigned NUM_WAYS   = 2;    // hit encoding and victim counter rely on this
  localparam int unsigned LINE_BYTES = 1 << OFFSET_W;
  localparam int unsigned LINE_W     = LINE_BYTES * 8;

  typedef logic [TAG_W-1:0]      tag_t;
  typedef logic [INDEX_W-1:0]    index_t;
  typedef logic                  way_t;
  typedef logic [LINE_W-1:0]     line_t;
  typedef logic [LINE_BYTES-1:0] line_be_t;

  // offset bit 3 picks the 64-bit word inside the line
  typedef struct packed {
    tag_t                tag;
    index_t              index;
    logic [OFFSET_W-1:0] offset;
  } dcache_addr_t;

  // one write into the tag array, 31 bits
  typedef struct packed {
    way_t   way;
    index_t index;
    tag_t   tag;
    logic   valid;
    logic   dirty;
  } tag_upd_t;

  typedef enum logic [2:0] {
    S_IDLE,
    S_HIT,
    S_AW,   // write-back address
    S_W,    // write-back beats
    S_B,
    S_AR,   // refill address
    S_R     // refill beats
  } dcache_state_e;

endpackage

`default_nettype wire

//--- rtl/dcache_tag_array.sv
// two ways only; victim way changes every cycle so the user must latch victim outputs
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_array
  import dcache_pkg::*;
(
  input  wire               clk,
  input  wire               rst,
  input  wire dcache_addr_t lookup_i,
  output logic              hit_o,
  output way_t              hit_way_o,
  output way_t              victim_way_o,
  output logic              victim_dirty_o,
  output tag_t              victim_tag_o,
  input  wire               upd_en_i,
  input  wire tag_upd_t     upd_i
);

  tag_t                tag_q   [NUM_WAYS][NUM_SETS];
  logic [NUM_SETS-1:0] valid_q [NUM_WAYS];
  logic [NUM_SETS-1:0] dirty_q [NUM_WAYS];
  way_t                victim_q;
  logic [NUM_WAYS-1:0] way_hit;

  // free-running replacement counter
  always_ff @(posedge clk) begin
    if (rst) begin
      victim_q <= 1'b0;
    end else begin
      victim_q <= ~victim_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q[0] <= '0;
      valid_q[1] <= '0;
      dirty_q[0] <= '0;
      dirty_q[1] <= '0;
    end else if (upd_en_i) begin
      valid_q[upd_i.way][upd_i.index] <= upd_i.valid;
      dirty_q[upd_i.way][upd_i.index] <= upd_i.dirty;
    end
  end

  // stored tag per way and set
  always_ff @(posedge clk) begin
    if (upd_en_i) begin
      tag_q[upd_i.way][upd_i.index] <= upd_i.tag;
    end
  end

  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      way_hit[w] = valid_q[w][lookup_i.index] && (tag_q[w][lookup_i.index] == lookup_i.tag);
    end
  end

  assign hit_o     = |way_hit;
  assign hit_way_o = way_hit[1];  // 2-way encode

  assign victim_way_o   = victim_q;
  assign victim_dirty_o = valid_q[victim_q][lookup_i.index] && dirty_q[victim_q][lookup_i.index];
  assign victim_tag_o   = tag_q[victim_q][lookup_i.index];

endmodule

`default_nettype wire

//--- rtl/dcache_top.sv
// data cache subsystem, 2-way 64-set write-back; memory side expects exactly 2-beat bursts
`timescale 1ns/1ps
`default_nettype none

module dcache_top
  import dcache_pkg::*;
  import bus_pkg::*;
(
  input  wire               clk,
  input  wire               rst,
  input  wire               core_ar_valid_i,
  output logic              core_ar_ready_o,
  input  wire dcache_addr_t core_ar_addr_i,
  output logic              core_r_valid_o,
  input  wire               core_r_ready_i,
  output bus_word_t         core_r_data_o,
  input  wire               core_aw_valid_i,
  output logic              core_aw_ready_o,
  input  wire dcache_addr_t core_aw_addr_i,
  input  wire               core_w_valid_i,
  output logic              core_w_ready_o,
  input  wire wbeat_t       core_w_i,
  output logic              core_b_valid_o,
  input  wire               core_b_ready_i,
  output bus_resp_e         core_b_resp_o,
  output logic              mem_ar_valid_o,
  input  wire               mem_ar_ready_i,
  output dcache_addr_t      mem_ar_addr_o,
  input  wire               mem_r_valid_i,
  output logic              mem_r_ready_o,
  input  wire bus_word_t    mem_r_data_i,
  input  wire bus_resp_e    mem_r_resp_i,
  output logic              mem_aw_valid_o,
  input  wire               mem_aw_ready_i,
  output dcache_addr_t      mem_aw_addr_o,
  output logic              mem_w_valid_o,
  input  wire               mem_w_ready_i,
  output wbeat_t            mem_w_o,
  input  wire               mem_b_valid_i,
  output logic              mem_b_ready_o,
  input  wire bus_resp_e    mem_b_resp_i
);

  dcache_addr_t lookup;
  logic         hit;
  way_t         hit_way;
  way_t         victim_way;
  logic         victim_dirty;
  tag_t         victim_tag;
  logic         upd_en;
  tag_upd_t     upd;
  logic [1:0]   way_we;
  index_t       ram_index;
  line_be_t     ram_be;
  line_t        ram_wdata;
  line_t        way0_rdata;
  line_t        way1_rdata;

  dcache_ctrl u_ctrl (
    .clk             (clk),
    .rst             (rst),
    .core_ar_valid_i (core_ar_valid_i),
    .core_ar_ready_o (core_ar_ready_o),
    .core_ar_addr_i  (core_ar_addr_i),
    .core_r_valid_o  (core_r_valid_o),
    .core_r_ready_i  (core_r_ready_i),
    .core_r_data_o   (core_r_data_o),
    .core_aw_valid_i (core_aw_valid_i),
    .core_aw_ready_o (core_aw_ready_o),
    .core_aw_addr_i  (core_aw_addr_i),
    .core_w_valid_i  (core_w_valid_i),
    .core_w_ready_o  (core_w_ready_o),
    .core_w_i        (core_w_i),
    .core_b_valid_o  (core_b_valid_o),
    .core_b_ready_i  (core_b_ready_i),
    .core_b_resp_o   (core_b_resp_o),
    .mem_ar_valid_o  (mem_ar_valid_o),
    .mem_ar_ready_i  (mem_ar_ready_i),
    .mem_ar_addr_o   (mem_ar_addr_o),
    .mem_r_valid_i   (mem_r_valid_i),
    .mem_r_ready_o   (mem_r_ready_o),
    .mem_r_data_i    (mem_r_data_i),
    .mem_r_resp_i    (mem_r_resp_i),
    .mem_aw_valid_o  (mem_aw_valid_o),
    .mem_aw_ready_i  (mem_aw_ready_i),
    .mem_aw_addr_o   (mem_aw_addr_o),
    .mem_w_valid_o   (mem_w_valid_o),
    .mem_w_ready_i   (mem_w_ready_i),
    .mem_w_o         (mem_w_o),
    .mem_b_valid_i   (mem_b_valid_i),
    .mem_b_ready_o   (mem_b_ready_o),
    .mem_b_resp_i    (mem_b_resp_i),
    .lookup_o        (lookup),
    .hit_i           (hit),
    .hit_way_i       (hit_way),
    .victim_way_i    (victim_way),
    .victim_dirty_i  (victim_dirty),
    .victim_tag_i    (victim_tag),
    .upd_en_o        (upd_en),
    .upd_o           (upd),
    .way_we_o        (way_we),
    .ram_index_o     (ram_index),
    .ram_be_o        (ram_be),
    .ram_wdata_o     (ram_wdata),
    .way0_rdata_i    (way0_rdata),
    .way1_rdata_i    (way1_rdata)
  );

  dcache_tag_array u_tags (
    .clk            (clk),
    .rst            (rst),
    .lookup_i       (lookup),
    .hit_o          (hit),
    .hit_way_o      (hit_way),
    .victim_way_o   (victim_way),
    .victim_dirty_o (victim_dirty),
    .victim_tag_o   (victim_tag),
    .upd_en_i       (upd_en),
    .upd_i          (upd)
  );

  // both ways share index, enables and write data
  dcache_data_ram u_way0 (
    .clk     (clk),
    .we_i    (way_we[0]),
    .addr_i  (ram_index),
    .be_i    (ram_be),
    .wdata_i (ram_wdata),
    .rdata_o (way0_rdata)
  );

  dcache_data_ram u_way1 (
    .clk     (clk),
    .we_i    (way_we[1]),
    .addr_i  (ram_index),
    .be_i    (ram_be),
    .wdata_i (ram_wdata),
    .rdata_o (way1_rdata)
  );

endmodule

`default_nettype wire

//--- sim/dcache_assert.sv
// handshake checks for the cache controller, bound into every dcache_ctrl instance
`timescale 1ns/1ps
`default_nettype none

module dcache_assert
  import dcache_pkg::*;
  import bus_pkg::*;
(
  input wire               clk,
  input wire               rst,
  input wire               core_ar_ready_i,
  input wire               core_r_valid_i,
  input wire               core_r_ready_i,
  input wire bus_word_t    core_r_data_i,
  input wire               core_b_valid_i,
  input wire               core_b_ready_i,
  input wire bus_resp_e    core_b_resp_i,
  input wire               mem_ar_valid_i,
  input wire               mem_ar_ready_i,
  input wire dcache_addr_t mem_ar_addr_i,
  input wire               mem_aw_valid_i,
  input wire               mem_aw_ready_i,
  input wire dcache_addr_t mem_aw_addr_i,
  input wire               mem_w_valid_i,
  input wire               mem_w_ready_i,
  input wire wbeat_t       mem_w_i
);

  // a stalled valid keeps itself and its payload
  core_r_hold: assert property (@(posedge clk) disable iff (rst)
    core_r_valid_i && !core_r_ready_i |=> core_r_valid_i && $stable(core_r_data_i))
    else $error("core r valid or data changed while stalled");

  core_b_hold: assert property (@(posedge clk) disable iff (rst)
    core_b_valid_i && !core_b_ready_i |=> core_b_valid_i && $stable(core_b_resp_i))
    else $error("core b valid or resp changed while stalled");

  mem_ar_hold: assert property (@(posedge clk) disable iff (rst)
    mem_ar_valid_i && !mem_ar_ready_i |=> mem_ar_valid_i && $stable(mem_ar_addr_i))
    else $error("mem ar valid or address changed while stalled");

  mem_aw_hold: assert property (@(posedge clk) disable iff (rst)
    mem_aw_valid_i && !mem_aw_ready_i |=> mem_aw_valid_i && $stable(mem_aw_addr_i))
    else $error("mem aw valid or address changed while stalled");

  mem_w_hold: assert property (@(posedge clk) disable iff (rst)
    mem_w_valid_i && !mem_w_ready_i |=> mem_w_valid_i && $stable(mem_w_i))
    else $error("mem w valid or beat changed while stalled");

  // new address only once the data is gone
  ar_vs_r: assert property (@(posedge clk) disable iff (rst)
    !(core_ar_ready_i && core_r_valid_i))
    else $error("core ar ready and r valid high together");

endmodule

bind dcache_ctrl dcache_assert u_assert (
  .clk             (clk),
  .rst             (rst),
  .core_ar_ready_i (core_ar_ready_o),
  .core_r_valid_i  (core_r_valid_o),
  .core_r_ready_i  (core_r_ready_i),
  .core_r_data_i   (core_r_data_o),
  .core_b_valid_i  (core_b_valid_o),
  .core_b_ready_i  (core_b_ready_i),
  .core_b_resp_i   (core_b_resp_o),
  .mem_ar_valid_i  (mem_ar_valid_o),
  .mem_ar_ready_i  (mem_ar_ready_i),
  .mem_ar_addr_i   (mem_ar_addr_o),
  .mem_aw_valid_i  (mem_aw_valid_o),
  .mem_aw_ready_i  (mem_aw_ready_i),
  .mem_aw_addr_i   (mem_aw_addr_o),
  .mem_w_valid_i   (mem_w_valid_o),
  .mem_w_ready_i   (mem_w_ready_i),
  .mem_w_i         (mem_w_o)
);

`default_nettype wire

//--- sim/dcache_mem_model.sv
// sparse backing memory for 2-beat bursts only; ready and valid delays are random, always OKAY
`timescale 1ns/1ps
`default_nettype none

module dcache_mem_model
  import dcache_pkg::*;
  import bus_pkg::*;
#(
  parameter int unsigned SEED = 32'h7af
) (
  input  wire               clk,
  input  wire               rst,
  input  wire               ar_valid_i,
  output logic              ar_ready_o = 1'b0,
  input  wire dcache_addr_t ar_addr_i,
  output logic              r_valid_o = 1'b0,
  input  wire               r_ready_i,
  output bus_word_t         r_data_o = '0,
  output bus_resp_e         r_resp_o,
  input  wire               aw_valid_i,
  output logic              aw_ready_o = 1'b0,
  input  wire dcache_addr_t aw_addr_i,
  input  wire               w_valid_i,
  output logic              w_ready_o = 1'b0,
  input  wire wbeat_t       w_i,
  output logic              b_valid_o = 1'b0,
  input  wire               b_ready_i,
  output bus_resp_e         b_resp_o
);

  bus_word_t   words [logic [28:0]];  // keyed by word address
  logic [28:0] rd_word;
  logic [28:0] wr_word;
  logic [1:0]  rd_left;
  logic [1:0]  wr_left;
  bus_word_t   cur;
  logic        seeded = 1'b0;

  assign r_resp_o = OKAY;
  assign b_resp_o = OKAY;

  // untouched words: address on top, inverse below
  function automatic bus_word_t read_word(input logic [28:0] wa);
    if (words.exists(wa)) begin
      return words[wa];
    end
    return {3'b000, wa, ~{3'b000, wa}};
  endfunction

  always @(posedge clk) begin
    if (!seeded) begin
      void'($urandom(SEED));  // one seed for every draw below
      seeded = 1'b1;
    end
    if (rst) begin
      ar_ready_o <= 1'b0;
      r_valid_o  <= 1'b0;
      aw_ready_o <= 1'b0;
      w_ready_o  <= 1'b0;
      b_valid_o  <= 1'b0;
      rd_left    <= 2'd0;
      wr_left    <= 2'd0;
    end else begin
      // read burst
      if (rd_left == 2'd0) begin
        if (ar_valid_i && ar_ready_o) begin
          rd_word    <= {ar_addr_i.tag, ar_addr_i.index, 1'b0};
          rd_left    <= 2'd2;
          ar_ready_o <= 1'b0;
        end else begin
          ar_ready_o <= ($urandom % 2) == 0;
        end
      end else if (r_valid_o) begin
        if (r_ready_i) begin
          r_valid_o <= 1'b0;
          rd_word   <= rd_word + 29'd1;  // low word first
          rd_left   <= rd_left - 2'd1;
        end
      end else if (($urandom % 3) != 0) begin
        r_valid_o <= 1'b1;
        r_data_o  <= read_word(rd_word);
      end
      // write burst, then one response
      if (wr_left == 2'd0 && !b_valid_o) begin
        if (aw_valid_i && aw_ready_o) begin
          wr_word    <= {aw_addr_i.tag, aw_addr_i.index, 1'b0};
          wr_left    <= 2'd2;
          aw_ready_o <= 1'b0;
        end else begin
          aw_ready_o <= ($urandom % 2) == 0;
        end
      end else if (wr_left != 2'd0) begin
        if (w_valid_i && w_ready_o) begin
          cur = read_word(wr_word);
          for (int b = 0; b < 8; b++) begin
            if (w_i.strb[b]) begin
              cur[b*8 +: 8] = w_i.data[b*8 +: 8];
            end
          end
          words[wr_word] = cur;
          wr_word   <= wr_word + 29'd1;
          wr_left   <= wr_left - 2'd1;
          w_ready_o <= 1'b0;
          b_valid_o <= (wr_left == 2'd1);  // last beat
        end else begin
          w_ready_o <= ($urandom % 2) == 0;
        end
      end else if (b_ready_i) begin
        b_valid_o <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- sim/dcache_tb.sv
// one request at a time from a fixed table; the first wrong value ends the run
`timescale 1ns/1ps
`default_nettype none

module dcache_tb
  import dcache_pkg::*;
  import bus_pkg::*;
;

  localparam int RESET_CYCLES = 3;
  localparam int STEP_CYCLES  = 300;

  typedef enum logic {OP_RD, OP_WR} op_e;

  typedef struct {
    string        name;
    op_e          op;
    dcache_addr_t addr;
    bus_word_t    wdata;
    logic [7:0]   strb;
    int           delay;  // cycles core holds r/b ready low
    int           lat;    // edges from accept to r/b transfer, 0 skips
  } step_t;

  logic         clk = 1'b0;
  logic         rst = 1'b1;
  int           cyc = 0;
  step_t        steps [$];
  bus_word_t    shadow [logic [28:0]];

  logic         core_ar_valid = 1'b0;
  logic         core_ar_ready;
  dcache_addr_t core_ar_addr = '0;
  logic         core_r_valid;
  logic         core_r_ready = 1'b0;
  bus_word_t    core_r_data;
  logic         core_aw_valid = 1'b0;
  logic         core_aw_ready;
  dcache_addr_t core_aw_addr = '0;
  logic         core_w_valid = 1'b0;
  logic         core_w_ready;
  wbeat_t       core_w = '0;
  logic         core_b_valid;
  logic         core_b_ready = 1'b0;
  bus_resp_e    core_b_resp;
  logic         mem_ar_valid;
  logic         mem_ar_ready;
  dcache_addr_t mem_ar_addr;
  logic         mem_r_valid;
  logic         mem_r_ready;
  bus_word_t    mem_r_data;
  bus_resp_e    mem_r_resp;
  logic         mem_aw_valid;
  logic         mem_aw_ready;
  dcache_addr_t mem_aw_addr;
  logic         mem_w_valid;
  logic         mem_w_ready;
  wbeat_t       mem_w;
  logic         mem_b_valid;
  logic         mem_b_ready;
  bus_resp_e    mem_b_resp;

  always #10 clk = ~clk;

  dcache_top dcache_top_i (
    .clk (clk), .rst (rst),
    .core_ar_valid_i (core_ar_valid), .core_ar_ready_o (core_ar_ready),
    .core_ar_addr_i  (core_ar_addr),
    .core_r_valid_o  (core_r_valid),  .core_r_ready_i  (core_r_ready),
    .core_r_data_o   (core_r_data),
    .core_aw_valid_i (core_aw_valid), .core_aw_ready_o (core_aw_ready),
    .core_aw_addr_i  (core_aw_addr),
    .core_w_valid_i  (core_w_valid),  .core_w_ready_o  (core_w_ready),
    .core_w_i        (core_w),
    .core_b_valid_o  (core_b_valid),  .core_b_ready_i  (core_b_ready),
    .core_b_resp_o   (core_b_resp),
    .mem_ar_valid_o  (mem_ar_valid),  .mem_ar_ready_i  (mem_ar_ready),
    .mem_ar_addr_o   (mem_ar_addr),
    .mem_r_valid_i   (mem_r_valid),   .mem_r_ready_o   (mem_r_ready),
    .mem_r_data_i    (mem_r_data),    .mem_r_resp_i    (mem_r_resp),
    .mem_aw_valid_o  (mem_aw_valid),  .mem_aw_ready_i  (mem_aw_ready),
    .mem_aw_addr_o   (mem_aw_addr),
    .mem_w_valid_o   (mem_w_valid),   .mem_w_ready_i   (mem_w_ready),
    .mem_w_o         (mem_w),
    .mem_b_valid_i   (mem_b_valid),   .mem_b_ready_o   (mem_b_ready),
    .mem_b_resp_i    (mem_b_resp)
  );

  dcache_mem_model #(.SEED(32'h7af)) u_mem (
    .clk (clk), .rst (rst),
    .ar_valid_i (mem_ar_valid), .ar_ready_o (mem_ar_ready), .ar_addr_i (mem_ar_addr),
    .r_valid_o  (mem_r_valid),  .r_ready_i  (mem_r_ready),  .r_data_o  (mem_r_data),
    .r_resp_o   (mem_r_resp),
    .aw_valid_i (mem_aw_valid), .aw_ready_o (mem_aw_ready), .aw_addr_i (mem_aw_addr),
    .w_valid_i  (mem_w_valid),  .w_ready_o  (mem_w_ready),  .w_i       (mem_w),
    .b_valid_o  (mem_b_valid),  .b_ready_i  (mem_b_ready),  .b_resp_o  (mem_b_resp)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_word(input string name, input bus_word_t exp_w, input bus_word_t act_w);
    if (exp_w !== act_w) begin
      fail_run($sformatf("MISMATCH %s: expected %h, actual %h", name, exp_w, act_w));
    end
  endtask

  task automatic check_resp(input string name, input bus_resp_e exp_r, input bus_resp_e act_r);
    if (exp_r !== act_r) begin
      fail_run($sformatf("MISMATCH %s: expected %s, actual %s", name, exp_r.name(),
                         act_r.name()));
    end
  endtask

  task automatic check_latency(input string name, input int exp_l, input int act_l);
    if (exp_l != act_l) begin
      fail_run($sformatf("MISMATCH %s: expected %0d edges, actual %0d edges", name, exp_l,
                         act_l));
    end
  endtask

  task automatic add_step(input string name, input op_e op, input dcache_addr_t addr,
                          input bus_word_t wdata, input logic [7:0] strb, input int delay,
                          input int lat);
    step_t s;
    s.name  = name;
    s.op    = op;
    s.addr  = addr;
    s.wdata = wdata;
    s.strb  = strb;
    s.delay = delay;
    s.lat   = lat;
    steps.push_back(s);
  endtask

  // memory word never written: word address high, its inverse low
  function automatic bus_word_t expected_word(input logic [28:0] wa);
    if (shadow.exists(wa)) begin
      return shadow[wa];
    end
    return {3'b000, wa, 3'b111, ~wa};
  endfunction

  task automatic run_read(input step_t s);
    bus_word_t want;
    bus_word_t held;
    int        t_accept;
    want = expected_word(s.addr[31:3]);
    @(posedge clk);
    core_ar_valid <= 1'b1;
    core_ar_addr  <= s.addr;
    core_r_ready  <= (s.delay == 0);
    @(negedge clk);
    while (!core_ar_ready) @(negedge clk);
    t_accept = cyc;
    @(posedge clk);
    core_ar_valid <= 1'b0;
    @(negedge clk);
    while (!core_r_valid) @(negedge clk);
    held = core_r_data;
    repeat (s.delay) begin
      @(posedge clk);
      @(negedge clk);
      if (!core_r_valid) fail_run($sformatf("r valid dropped while stalled in %s", s.name));
      check_word(s.name, held, core_r_data);
    end
    if (s.delay != 0) begin
      @(posedge clk);
      core_r_ready <= 1'b1;
      @(negedge clk);
    end
    check_word(s.name, want, core_r_data);  // transfers on the next edge
    if (s.lat != 0) check_latency(s.name, s.lat, cyc - t_accept);
    @(posedge clk);
    core_r_ready <= 1'b0;
  endtask

  task automatic run_write(input step_t s);
    bus_word_t merged;
    bus_resp_e held;
    int        t_accept;
    merged = expected_word(s.addr[31:3]);
    for (int b = 0; b < 8; b++) begin
      if (s.strb[b]) merged[b*8 +: 8] = s.wdata[b*8 +: 8];
    end
    shadow[s.addr[31:3]] = merged;
    @(posedge clk);
    core_aw_valid <= 1'b1;
    core_aw_addr  <= s.addr;
    core_b_ready  <= (s.delay == 0);
    @(negedge clk);
    while (!core_aw_ready) @(negedge clk);
    t_accept = cyc;
    @(posedge clk);
    core_aw_valid <= 1'b0;
    core_w_valid  <= 1'b1;
    core_w        <= '{data: s.wdata, strb: s.strb};
    @(negedge clk);
    while (!core_w_ready) @(negedge clk);
    @(posedge clk);
    core_w_valid <= 1'b0;
    @(negedge clk);
    while (!core_b_valid) @(negedge clk);
    held = core_b_resp;
    repeat (s.delay) begin
      @(posedge clk);
      @(negedge clk);
      if (!core_b_valid) fail_run($sformatf("b valid dropped while stalled in %s", s.name));
      check_resp(s.name, held, core_b_resp);
    end
    if (s.delay != 0) begin
      @(posedge clk);
      core_b_ready <= 1'b1;
      @(negedge clk);
    end
    check_resp(s.name, OKAY, core_b_resp);
    if (s.lat != 0) check_latency(s.name, s.lat, cyc - t_accept);
    @(posedge clk);
    core_b_ready <= 1'b0;
  endtask

  task automatic build_table();
    add_step("read_miss_lo", OP_RD, 32'h0000_1040, '0, 8'h00, 0, 0);
    add_step("read_miss_hi", OP_RD, 32'h0000_2088, '0, 8'h00, 0, 0);
    add_step("read_hit", OP_RD, 32'h0000_1040, '0, 8'h00, 0, 2);
    add_step("write_hit", OP_WR, 32'h0000_1048, 64'hdead_beef_0123_4567, 8'h0f, 0, 2);
    add_step("read_merged", OP_RD, 32'h0000_1048, '0, 8'h00, 0, 2);
    add_step("write_miss", OP_WR, 32'h0000_3010, 64'h1122_3344_5566_7788, 8'hf0, 0, 0);
    add_step("read_alloc", OP_RD, 32'h0000_3010, '0, 8'h00, 0, 2);
    // four tags on index 0x20 force dirty evictions
    add_step("evict_wr_a", OP_WR, 32'h0001_0200, 64'ha5a5_0001_5a5a_1000, 8'hff, 0, 0);
    add_step("evict_wr_b", OP_WR, 32'h0002_0208, 64'hb6b6_0002_6b6b_2000, 8'hff, 0, 0);
    add_step("evict_wr_c", OP_WR, 32'h0003_0200, 64'hc7c7_0003_7c7c_3000, 8'h3c, 0, 0);
    add_step("evict_wr_d", OP_WR, 32'h0004_0208, 64'hd8d8_0004_8d8d_4000, 8'hff, 0, 0);
    add_step("evict_rd_a", OP_RD, 32'h0001_0200, '0, 8'h00, 0, 0);
    add_step("evict_rd_b", OP_RD, 32'h0002_0208, '0, 8'h00, 0, 0);
    add_step("evict_rd_c", OP_RD, 32'h0003_0200, '0, 8'h00, 0, 0);
    add_step("evict_rd_d", OP_RD, 32'h0004_0208, '0, 8'h00, 0, 0);
    add_step("stall_read", OP_RD, 32'h0003_0208, '0, 8'h00, 5, 0);
    add_step("stall_write", OP_WR, 32'h0001_0208, 64'h0f1e_2d3c_4b5a_6978, 8'h81, 4, 0);
    add_step("stall_readback", OP_RD, 32'h0001_0208, '0, 8'h00, 3, 0);
  endtask

  // run limit scales with the table
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc > RESET_CYCLES + STEP_CYCLES * steps.size()) begin
      fail_run("timeout, the cache stopped answering handshakes");
    end
  end

  initial begin
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    if (!core_ar_ready || !core_aw_ready || core_r_valid || core_b_valid || mem_ar_valid ||
        mem_aw_valid || mem_w_valid || mem_r_ready || mem_b_ready) begin
      fail_run("handshake outputs not at their reset values");
    end
    foreach (steps[i]) begin
      if (steps[i].op == OP_WR) begin
        run_write(steps[i]);
      end else begin
        run_read(steps[i]);
      end
    end
    repeat (2) @(posedge clk);
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire
